// File: include/mvu_settings.svh
`ifndef MVU_SETTINGS_SVH
`define MVU_SETTINGS_SVH

// Lanes per bit-plane word
`define MVU_LANES       16

// Precision fields hold length - 1, so 3 bits cover up to 8-bit operands
`define MVU_BPREC       3

// Weight and data memories
`define MVU_MEM_DEPTH   64
`define MVU_ADDR_W      6

// Datapath widths
`define MVU_CNT_W       5    // Popcount of 16 lanes
`define MVU_SHIFT_W     4    // Max bit weight is 7 + 7
`define MVU_ACC_W       24

// Pipeline latencies
`define MVU_RD_LATENCY  1
`define MVU_PC_STAGES   1

`endif

// File: source/mvu_job_pkg.sv
`default_nettype none

`include "mvu_settings.svh"

package mvu_job_pkg;

    // One job as seen by the host and the register block
    typedef struct packed {
        logic [`MVU_BPREC-1:0]  wprecision;  // Weight bits - 1
        logic [`MVU_BPREC-1:0]  iprecision;  // Input bits - 1
        logic [`MVU_ADDR_W-1:0] wbaseaddr;   // Weight plane of bit 0
        logic [`MVU_ADDR_W-1:0] ibaseaddr;   // Input plane of bit 0
        logic                   w_signed;
        logic                   d_signed;
    } job_cfg_t;

endpackage

`default_nettype wire

// File: source/mvu_dp_pkg.sv
`default_nettype none

`include "mvu_settings.svh"

package mvu_dp_pkg;

    // Bit b of every lane, lane k in bit k
    typedef logic [`MVU_LANES-1:0] plane_t;

    // Host write into one of the two memories
    typedef struct packed {
        logic                   en;
        logic                   sel;   // 1 selects the weight memory
        logic [`MVU_ADDR_W-1:0] addr;
        plane_t                 word;
    } mem_wr_t;

    // Control that travels with one bit-pair term
    typedef struct packed {
        logic                    valid;
        logic                    first;  // Load instead of add
        logic                    last;
        logic                    neg;
        logic [`MVU_SHIFT_W-1:0] shift;  // Sum of both bit indices
    } acc_ctrl_t;

endpackage

`default_nettype wire

// File: source/mvu_job_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "mvu_settings.svh"

module mvu_job_regs
    import mvu_job_pkg::*;
(
    input  logic     intf,
    input  logic     rst_n,
    input  logic     start,
    input  job_cfg_t job,
    input  logic     busy,
    output job_cfg_t cfg,
    output logic     go
);

    logic accept;

    // The go cycle is also refused since busy only rises the cycle after it
    assign accept = start & ~busy & ~go;

    always_ff @(posedge intf or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= '0;
            go  <= 1'b0;
        end else begin
            go <= accept;         // Delayed start, lines up with cfg
            if (accept) begin
                cfg <= job;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/mvu_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "mvu_settings.svh"

module mvu_sequencer
    import mvu_job_pkg::*;
    import mvu_dp_pkg::*;
(
    input  logic                   intf,
    input  logic                   rst_n,
    input  logic                   go,
    input  job_cfg_t               cfg,
    output logic [`MVU_ADDR_W-1:0] waddr,
    output logic [`MVU_ADDR_W-1:0] daddr,
    output acc_ctrl_t              ctrl,
    output logic                   busy
);

    // Cycles from the last term leaving here to result_valid in the datapath
    localparam int DRAIN = `MVU_RD_LATENCY + `MVU_PC_STAGES;

    logic [`MVU_BPREC-1:0] ibit;   // Current input bit
    logic [`MVU_BPREC-1:0] wbit;   // Current weight bit
    logic                  run;
    logic [1:0]            drain;
    logic                  i_msb;
    logic                  w_msb;

    assign i_msb = (ibit == cfg.iprecision);
    assign w_msb = (wbit == cfg.wprecision);

    // Planes sit at base + bit index
    assign waddr = cfg.wbaseaddr + `MVU_ADDR_W'(wbit);
    assign daddr = cfg.ibaseaddr + `MVU_ADDR_W'(ibit);

    always_comb begin
        ctrl.valid = run;
        ctrl.first = run & i_msb & w_msb;
        ctrl.last  = run & (ibit == '0) & (wbit == '0);
        // Signed MSB carries negative weight, two of them cancel
        ctrl.neg   = run & ((cfg.d_signed & i_msb) ^ (cfg.w_signed & w_msb));
        ctrl.shift = `MVU_SHIFT_W'(ibit) + `MVU_SHIFT_W'(wbit);
    end

    always_ff @(posedge intf or negedge rst_n) begin
        if (!rst_n) begin
            ibit  <= '0;
            wbit  <= '0;
            run   <= 1'b0;
            drain <= '0;
            busy  <= 1'b0;
        end else if (go) begin
            // Start at the MSB pair
            ibit <= cfg.iprecision;
            wbit <= cfg.wprecision;
            run  <= 1'b1;
            busy <= 1'b1;
        end else if (run) begin
            if (wbit == '0) begin
                wbit <= cfg.wprecision;   // Weight loop wraps
                if (ibit == '0) begin
                    run   <= 1'b0;
                    drain <= 2'(DRAIN);
                end else begin
                    ibit <= ibit - 1'b1;
                end
            end else begin
                wbit <= wbit - 1'b1;
            end
        end else if (drain != '0) begin
            drain <= drain - 1'b1;
            // Same edge that raises result_valid
            if (drain == 2'd1) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/bitplane_mem.sv
`timescale 1ns/10ps
`default_nettype none

`include "mvu_settings.svh"

module bitplane_mem
    import mvu_dp_pkg::*;
(
    input  logic                   intf,
    input  logic                   wr_en,
    input  logic [`MVU_ADDR_W-1:0] wr_addr,
    input  plane_t                 wr_word,
    input  logic [`MVU_ADDR_W-1:0] rd_addr,
    output plane_t                 rd_word
);

    plane_t mem [`MVU_MEM_DEPTH];

    always_ff @(posedge intf) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
        rd_word <= mem[rd_addr];   // One cycle read latency
    end

endmodule

`default_nettype wire

// File: source/mvu_datapath.sv
`timescale 1ns/10ps
`default_nettype none

`include "mvu_settings.svh"

module mvu_datapath
    import mvu_dp_pkg::*;
(
    input  logic                         intf,
    input  logic                         rst_n,
    input  acc_ctrl_t                    ctrl,
    input  plane_t                       wword,
    input  plane_t                       dword,
    output logic signed [`MVU_ACC_W-1:0] result,
    output logic                         result_valid
);

    // Control waits for the memory read and the popcount register
    localparam int DLY = `MVU_RD_LATENCY + `MVU_PC_STAGES;

    acc_ctrl_t                    ctrl_q [DLY];
    acc_ctrl_t                    ctrl_acc;
    plane_t                       and_word;
    logic [`MVU_CNT_W-1:0]        pc_next;
    logic [`MVU_CNT_W-1:0]        pc_q;
    logic signed [`MVU_ACC_W-1:0] term_mag;
    logic signed [`MVU_ACC_W-1:0] term;
    logic signed [`MVU_ACC_W-1:0] acc;

    // One bit product per lane
    assign and_word = wword & dword;

    always_comb begin
        pc_next = '0;
        for (int k = 0; k < `MVU_LANES; k++) begin
            pc_next = pc_next + `MVU_CNT_W'(and_word[k]);
        end
    end

    always_ff @(posedge intf) begin
        pc_q <= pc_next;
    end

    always_ff @(posedge intf or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < DLY; s++) begin
                ctrl_q[s] <= '0;
            end
        end else begin
            ctrl_q[0] <= ctrl;
            for (int s = 1; s < DLY; s++) begin
                ctrl_q[s] <= ctrl_q[s-1];
            end
        end
    end

    assign ctrl_acc = ctrl_q[DLY-1];

    // Count weighted by 2^(i+w), sign from the MSB rule
    assign term_mag = {{(`MVU_ACC_W-`MVU_CNT_W){1'b0}}, pc_q} << ctrl_acc.shift;
    assign term     = ctrl_acc.neg ? -term_mag : term_mag;

    always_ff @(posedge intf or negedge rst_n) begin
        if (!rst_n) begin
            acc          <= '0;
            result_valid <= 1'b0;
        end else begin
            if (ctrl_acc.valid) begin
                acc <= ctrl_acc.first ? term : acc + term;
            end
            result_valid <= ctrl_acc.valid & ctrl_acc.last;
        end
    end

    assign result = acc;   // Held until the next job loads

endmodule

`default_nettype wire

// File: source/mvu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "mvu_settings.svh"

module mvu_top
    import mvu_job_pkg::*;
    import mvu_dp_pkg::*;
(
    input  logic                         intf,
    input  logic                         rst_n,
    input  logic                         start,
    input  job_cfg_t                     job,
    input  mem_wr_t                      mem_wr,
    output logic                         busy,
    output logic signed [`MVU_ACC_W-1:0] result,
    output logic                         result_valid
);

    job_cfg_t               cfg;
    logic                   go;
    logic [`MVU_ADDR_W-1:0] waddr;
    logic [`MVU_ADDR_W-1:0] daddr;
    acc_ctrl_t              ctrl;
    plane_t                 wword;
    plane_t                 dword;

    mvu_job_regs u_job_regs (
        .intf  (intf),
        .rst_n (rst_n),
        .start (start),
        .job   (job),
        .busy  (busy),
        .cfg   (cfg),
        .go    (go)
    );

    mvu_sequencer u_sequencer (
        .intf  (intf),
        .rst_n (rst_n),
        .go    (go),
        .cfg   (cfg),
        .waddr (waddr),
        .daddr (daddr),
        .ctrl  (ctrl),
        .busy  (busy)
    );

    // Host writes go to one memory by sel
    bitplane_mem weight_mem (
        .intf    (intf),
        .wr_en   (mem_wr.en & mem_wr.sel),
        .wr_addr (mem_wr.addr),
        .wr_word (mem_wr.word),
        .rd_addr (waddr),
        .rd_word (wword)
    );

    bitplane_mem data_mem (
        .intf    (intf),
        .wr_en   (mem_wr.en & ~mem_wr.sel),
        .wr_addr (mem_wr.addr),
        .wr_word (mem_wr.word),
        .rd_addr (daddr),
        .rd_word (dword)
    );

    mvu_datapath u_datapath (
        .intf         (intf),
        .rst_n        (rst_n),
        .ctrl         (ctrl),
        .wword        (wword),
        .dword        (dword),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

`default_nettype wire

// File: tb/mvu_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "mvu_settings.svh"

module mvu_tb
    import mvu_job_pkg::*;
    import mvu_dp_pkg::*;
();

    typedef struct packed {
        job_cfg_t   cfg;
        logic [1:0] fill;       // 0 random, 1 all ones, 2 MSB only
        logic       load;       // 0 reuses vectors already stored
        logic       dup_start;  // Second start while busy
    } job_entry_t;

    localparam int NJOBS = 12;

    logic                         intf;
    logic                         rst_n;
    logic                         start;
    job_cfg_t                     job;
    mem_wr_t                      mem_wr;
    logic                         busy;
    logic signed [`MVU_ACC_W-1:0] result;
    logic                         result_valid;

    job_entry_t  jobs [NJOBS];
    logic [7:0]  w_raw [`MVU_MEM_DEPTH][`MVU_LANES];   // Lane values by base
    logic [7:0]  d_raw [`MVU_MEM_DEPTH][`MVU_LANES];
    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    int          cycles;
    int          cycle_limit;

    mvu_top dut (
        .intf         (intf),
        .rst_n        (rst_n),
        .start        (start),
        .job          (job),
        .mem_wr       (mem_wr),
        .busy         (busy),
        .result       (result),
        .result_valid (result_valid)
    );

    always #4 intf = ~intf;

    always @(posedge intf) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic job_entry_t make_entry(int wp, int ip, bit ws, bit ds, int wb, int ib,
                                              bit load, int fill, bit dup);
        job_entry_t e;
        e.cfg = '{wprecision: wp[2:0], iprecision: ip[2:0], wbaseaddr: wb[5:0],
                  ibaseaddr: ib[5:0], w_signed: ws, d_signed: ds};
        e.fill = fill[1:0];
        e.load = load;
        e.dup_start = dup;
        return e;
    endfunction

    function automatic logic [7:0] gen_value(int prec, int fill);
        logic [7:0] mask;
        logic [31:0] r;
        mask = 8'((1 << (prec + 1)) - 1);
        r = lcg_next();
        if (fill == 1) return mask;
        if (fill == 2) return 8'(1 << prec);
        return r[23:16] & mask;
    endfunction

    // Two's complement when signed, plain binary otherwise
    function automatic int lane_value(logic [7:0] raw, int prec, bit sgn);
        int v;
        v = int'(raw) & ((1 << (prec + 1)) - 1);
        if (sgn && v[prec]) v = v - (1 << (prec + 1));
        return v;
    endfunction

    function automatic int dot_product(job_cfg_t c);
        int sum;
        sum = 0;
        for (int k = 0; k < `MVU_LANES; k++) begin
            sum += lane_value(w_raw[c.wbaseaddr][k], int'(c.wprecision), c.w_signed) *
                   lane_value(d_raw[c.ibaseaddr][k], int'(c.iprecision), c.d_signed);
        end
        return sum;
    endfunction

    task automatic step();
        @(posedge intf);
        #1;
    endtask

    task automatic write_plane(bit sel, int base, int prec, bit weight);
        plane_t word;
        for (int b = 0; b <= prec; b++) begin
            for (int k = 0; k < `MVU_LANES; k++) begin
                word[k] = weight ? w_raw[base][k][b] : d_raw[base][k][b];  // Lane k, bit b
            end
            step();
            mem_wr = '{en: 1'b1, sel: sel, addr: `MVU_ADDR_W'(base + b), word: word};
        end
    endtask

    task automatic run_job(int idx);
        job_entry_t e;
        job_cfg_t   alt;
        int         nterms;
        int         count;
        bit         seen;
        logic signed [`MVU_ACC_W-1:0] exp_acc;
        e = jobs[idx];
        nterms = (int'(e.cfg.wprecision) + 1) * (int'(e.cfg.iprecision) + 1);
        if (e.load) begin
            for (int k = 0; k < `MVU_LANES; k++) begin
                w_raw[e.cfg.wbaseaddr][k] = gen_value(int'(e.cfg.wprecision), int'(e.fill));
                d_raw[e.cfg.ibaseaddr][k] = gen_value(int'(e.cfg.iprecision), int'(e.fill));
            end
            write_plane(1'b1, int'(e.cfg.wbaseaddr), int'(e.cfg.wprecision), 1'b1);
            write_plane(1'b0, int'(e.cfg.ibaseaddr), int'(e.cfg.iprecision), 1'b0);
        end
        exp_acc = `MVU_ACC_W'(dot_product(e.cfg));
        alt = e.cfg;   // Would give another result if taken
        alt.iprecision = '0;
        alt.d_signed = ~e.cfg.d_signed;
        step();
        mem_wr.en = 1'b0;
        start = 1'b1;
        job = e.cfg;
        count = 0;
        seen = 1'b0;
        while (!seen && count < nterms + 12) begin
            step();
            count++;
            start = 1'b0;
            if (e.dup_start && count == 2) begin
                start = 1'b1;
                job = alt;
            end
            if (result_valid) begin
                seen = 1'b1;
                checks++;
                // Busy drops together with the result strobe
                assert (!busy) else begin
                    errors++;
                    $display("[FAIL] %0t job %0d busy still high with result_valid", $time,
                             idx);
                end
            end else if (count >= 2) begin
                checks++;
                assert (busy) else begin
                    errors++;
                    $display("[FAIL] %0t job %0d busy low at cycle %0d", $time, idx, count);
                end
            end
        end
        start = 1'b0;
        if (!seen) begin
            errors++;
            $display("Job %0d never raised result_valid", idx);
        end
        checks += 2;
        assert (count == nterms + 4) else begin
            errors++;
            $display("[FAIL] %0t job %0d latency %0d expected %0d", $time, idx, count,
                     nterms + 4);
        end
        assert (result == exp_acc) else begin
            errors++;
            $display("[FAIL] %0t job %0d result %0d expected %0d", $time, idx, result, exp_acc);
        end
        // Long enough to see a wrongly accepted second job
        repeat (e.dup_start ? nterms + 8 : 3) begin
            step();
            checks++;
            assert (!result_valid && result == exp_acc) else begin
                errors++;
                $display("[FAIL] %0t job %0d extra strobe or result moved to %0d", $time, idx,
                         result);
            end
        end
    endtask

    initial begin
        intf = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        job = '0;
        mem_wr = '0;
        lcg_state = 32'h0c3225b0;
        errors = 0;
        checks = 0;
        cycles = 0;
        //                     wp ip ws ds wb  ib  ld fill dup
        jobs[0]  = make_entry(0, 0, 0, 0, 0,  0,  1, 0, 0);
        jobs[1]  = make_entry(7, 7, 0, 0, 8,  8,  1, 0, 0);
        jobs[2]  = make_entry(7, 7, 0, 0, 16, 16, 1, 1, 0);
        jobs[3]  = make_entry(3, 5, 0, 1, 24, 24, 1, 0, 0);
        jobs[4]  = make_entry(5, 3, 1, 0, 32, 32, 1, 0, 0);
        jobs[5]  = make_entry(7, 7, 1, 1, 40, 40, 1, 0, 0);
        jobs[6]  = make_entry(7, 7, 1, 1, 48, 48, 1, 2, 0);
        jobs[7]  = make_entry(2, 4, 1, 1, 56, 56, 1, 1, 0);
        jobs[8]  = make_entry(7, 7, 0, 0, 8,  16, 0, 0, 0);  // Vectors of jobs 1 and 2
        jobs[9]  = make_entry(7, 7, 1, 1, 40, 8,  0, 0, 0);
        jobs[10] = make_entry(3, 3, 1, 1, 60, 60, 1, 0, 1);
        jobs[11] = make_entry(1, 6, 0, 1, 0,  0,  1, 0, 1);
        cycle_limit = 0;
        for (int j = 0; j < NJOBS; j++) begin
            cycle_limit += ((int'(jobs[j].cfg.wprecision) + 1) *
                            (int'(jobs[j].cfg.iprecision) + 1) + 20) * 2;
        end
        repeat (8) @(posedge intf);
        #1;
        rst_n = 1'b1;
        checks++;
        assert (!busy && !result_valid && result == '0) else begin
            errors++;
            $display("[FAIL] %0t after reset busy %b valid %b result %0d", $time, busy,
                     result_valid, result);
        end
        for (int j = 0; j < NJOBS; j++) begin
            run_job(j);
        end
        $display("Finished: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
source/mvu_job_pkg.sv
source/mvu_dp_pkg.sv
source/mvu_job_regs.sv
source/mvu_sequencer.sv
source/bitplane_mem.sv
source/mvu_datapath.sv
source/mvu_top.sv
tb/mvu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -Wno-fatal -f files.f --top-module mvu_tb \
    --Mdir obj_dir -o mvu_tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/mvu_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
    exit 1
fi
exit 0
